// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv_wrap
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
+incdir+src
src/conv_wrap_pkg.sv
src/cfg_target.sv
src/job_sequencer.sv
src/stream_sink.sv
src/stream_source.sv
src/conv_wrap_top.sv
testbench/tcdm_mem_model.sv
testbench/tb_conv_wrap.sv

// File: src/cfg_target.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_wrap_cfg.svh"

module cfg_target (
  input  wire                          clk_gated,
  input  wire                          rst_n,
  input  wire                          cfg_req_i,
  input  wire                          cfg_we_i,
  input  wire [`CW_CFG_ADDR_W-1:0]     cfg_addr_i,
  input  wire [`CW_DATA_W-1:0]         cfg_wdata_i,
  input  wire [`CW_ID_W-1:0]           cfg_id_i,
  input  wire                          busy_i,
  output logic                         cfg_r_valid_o,
  output logic [`CW_ID_W-1:0]          cfg_r_id_o,
  output logic [`CW_DATA_W-1:0]        cfg_r_rdata_o,
  output logic                         trigger_o,
  output conv_wrap_pkg::stream_desc_u  sink_desc_o,
  output conv_wrap_pkg::stream_desc_u  src_desc_o,
  output logic                         bypass_o,
  output logic [`CW_DATA_W-1:0]        const_o
);

  import conv_wrap_pkg::*;

  localparam int DW = `CW_DATA_W;

  stream_desc_u  sink_q;
  stream_desc_u  src_q;
  logic          bypass_q;
  logic [DW-1:0] const_q;
  logic [DW-1:0] rdata_d;
  logic          wr_en;
  logic          lock;

  // job owns the setup from the trigger pulse to the end of the job
  assign lock  = busy_i | trigger_o;
  assign wr_en = cfg_req_i & cfg_we_i;

  // setup registers, frozen while locked
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      sink_q   <= '0;
      src_q    <= '0;
      bypass_q <= 1'b0;
      const_q  <= '0;
    end else if (wr_en && !lock) begin
      case (cfg_addr_i)
        `CW_REG_SINK:   sink_q.raw <= cfg_wdata_i;
        `CW_REG_SOURCE: src_q.raw  <= cfg_wdata_i;
        // bit 0 selects the sum-over-constant bypass
        `CW_REG_CTRL:   bypass_q   <= cfg_wdata_i[0];
        `CW_REG_CONST:  const_q    <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  // start request, one pulse on the edge after the write
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      trigger_o <= 1'b0;
    end else begin
      trigger_o <= wr_en && !lock && (cfg_addr_i == `CW_REG_TRIGGER);
    end
  end

  // read mux, trigger and unmapped words read zero
  always_comb begin
    rdata_d = '0;
    case (cfg_addr_i)
      `CW_REG_STATUS: rdata_d = DW'(busy_i);
      `CW_REG_SINK:   rdata_d = sink_q.raw;
      `CW_REG_SOURCE: rdata_d = src_q.raw;
      `CW_REG_CTRL:   rdata_d = DW'(bypass_q);
      `CW_REG_CONST:  rdata_d = const_q;
      default:        rdata_d = '0;
    endcase
  end

  // one response per request, always one cycle later
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      cfg_r_valid_o <= 1'b0;
    end else begin
      cfg_r_valid_o <= cfg_req_i;
    end
  end

  always_ff @(posedge clk_gated) begin
    if (cfg_req_i) begin
      cfg_r_id_o    <= cfg_id_i;
      cfg_r_rdata_o <= rdata_d;
    end
  end

  assign sink_desc_o = sink_q;
  assign src_desc_o  = src_q;
  assign bypass_o    = bypass_q;
  assign const_o     = const_q;

  // no response without a request the cycle before
  a_resp_after_req : assert property (@(posedge clk_gated) disable iff (!rst_n)
    cfg_r_valid_o |-> $past(cfg_req_i));

endmodule

`default_nettype wire

// File: src/conv_wrap_cfg.svh
`ifndef CONV_WRAP_CFG_SVH
`define CONV_WRAP_CFG_SVH

// shared memory byte address width
`define CW_ADDR_W     32
// one data width for memory, stream and config words
`define CW_DATA_W     32
// config bus carries word addresses
`define CW_CFG_ADDR_W 4
// request id echoed back on the response
`define CW_ID_W       16
// length field of a stream descriptor
`define CW_LEN_W      16
// source response buffer entries
`define CW_FIFO_DEPTH 4

// register map, word addresses
`define CW_REG_TRIGGER 0
`define CW_REG_STATUS  1
`define CW_REG_SINK    2
`define CW_REG_SOURCE  3
`define CW_REG_CTRL    4
`define CW_REG_CONST   5

`endif

// File: src/conv_wrap_pkg.sv
`default_nettype none

`include "conv_wrap_cfg.svh"

package conv_wrap_pkg;

  // descriptor word
  // bus side sees the raw word, streamers see length and base
  typedef union packed {
    logic [`CW_DATA_W-1:0] raw;
    struct packed {
      // transfer length in words
      logic [`CW_LEN_W-1:0]            len;
      // base address in bytes
      logic [`CW_DATA_W-`CW_LEN_W-1:0] base;
    } fld;
  } stream_desc_u;

  // job sequencer states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    START  = 2'd1,
    RUN    = 2'd2,
    FINISH = 2'd3
  } seq_state_e;

endpackage

`default_nettype wire

// File: src/conv_wrap_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_wrap_cfg.svh"

module conv_wrap_top (
  input  wire                      clk_gated,
  input  wire                      rst_n,
  // configuration bus
  input  wire                      cfg_req_i,
  output logic                     cfg_gnt_o,
  input  wire                      cfg_we_i,
  input  wire [`CW_CFG_ADDR_W-1:0] cfg_addr_i,
  input  wire [`CW_DATA_W-1:0]     cfg_wdata_i,
  input  wire [`CW_ID_W-1:0]       cfg_id_i,
  output logic                     cfg_r_valid_o,
  output logic [`CW_ID_W-1:0]      cfg_r_id_o,
  output logic [`CW_DATA_W-1:0]    cfg_r_rdata_o,
  output logic                     evt_interrupt_o,
  output logic                     hwce_working_o,
  // engine result stream in
  input  wire                      sink_valid_i,
  input  wire [`CW_DATA_W-1:0]     sink_data_i,
  output logic                     sink_ready_o,
  // engine operand stream out
  output logic                     src_valid_o,
  output logic [`CW_DATA_W-1:0]    src_data_o,
  input  wire                      src_ready_i,
  // memory port 0, sink writes
  output logic                     mem0_req_o,
  input  wire                      mem0_gnt_i,
  output logic [`CW_ADDR_W-1:0]    mem0_addr_o,
  output logic                     mem0_we_o,
  output logic [`CW_DATA_W/8-1:0]  mem0_be_o,
  output logic [`CW_DATA_W-1:0]    mem0_wdata_o,
  // memory port 1, source reads
  output logic                     mem1_req_o,
  input  wire                      mem1_gnt_i,
  output logic [`CW_ADDR_W-1:0]    mem1_addr_o,
  output logic                     mem1_we_o,
  input  wire [`CW_DATA_W-1:0]     mem1_r_data_i,
  input  wire                      mem1_r_valid_i
);

  import conv_wrap_pkg::*;

  stream_desc_u          sink_desc;
  stream_desc_u          src_desc;
  logic                  trigger;
  logic                  bypass;
  logic [`CW_DATA_W-1:0] const_word;
  logic                  busy;
  logic                  start_sink;
  logic                  start_src;
  logic                  sink_done;
  logic                  src_done;

  // target never stalls
  assign cfg_gnt_o = 1'b1;

  cfg_target u_cfg (
    .clk_gated     (clk_gated),
    .rst_n         (rst_n),
    .cfg_req_i     (cfg_req_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_id_i      (cfg_id_i),
    .busy_i        (busy),
    .cfg_r_valid_o (cfg_r_valid_o),
    .cfg_r_id_o    (cfg_r_id_o),
    .cfg_r_rdata_o (cfg_r_rdata_o),
    .trigger_o     (trigger),
    .sink_desc_o   (sink_desc),
    .src_desc_o    (src_desc),
    .bypass_o      (bypass),
    .const_o       (const_word)
  );

  job_sequencer u_seq (
    .clk_gated       (clk_gated),
    .rst_n           (rst_n),
    .trigger_i       (trigger),
    .bypass_i        (bypass),
    .sink_done_i     (sink_done),
    .src_done_i      (src_done),
    .start_sink_o    (start_sink),
    .start_src_o     (start_src),
    .busy_o          (busy),
    .evt_interrupt_o (evt_interrupt_o),
    .hwce_working_o  (hwce_working_o)
  );

  stream_sink u_sink (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .start_i      (start_sink),
    .desc_i       (sink_desc),
    .sink_valid_i (sink_valid_i),
    .sink_data_i  (sink_data_i),
    .sink_ready_o (sink_ready_o),
    .mem_req_o    (mem0_req_o),
    .mem_gnt_i    (mem0_gnt_i),
    .mem_addr_o   (mem0_addr_o),
    .mem_we_o     (mem0_we_o),
    .mem_be_o     (mem0_be_o),
    .mem_wdata_o  (mem0_wdata_o),
    .done_o       (sink_done)
  );

  stream_source u_source (
    .clk_gated     (clk_gated),
    .rst_n         (rst_n),
    .start_i       (start_src),
    .bypass_i      (bypass),
    .const_i       (const_word),
    .desc_i        (src_desc),
    .mem_req_o     (mem1_req_o),
    .mem_gnt_i     (mem1_gnt_i),
    .mem_addr_o    (mem1_addr_o),
    .mem_we_o      (mem1_we_o),
    .mem_r_data_i  (mem1_r_data_i),
    .mem_r_valid_i (mem1_r_valid_i),
    .src_valid_o   (src_valid_o),
    .src_data_o    (src_data_o),
    .src_ready_i   (src_ready_i),
    .done_o        (src_done)
  );

endmodule

`default_nettype wire

// File: src/job_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module job_sequencer (
  input  wire  clk_gated,
  input  wire  rst_n,
  input  wire  trigger_i,
  input  wire  bypass_i,
  input  wire  sink_done_i,
  input  wire  src_done_i,
  output logic start_sink_o,
  output logic start_src_o,
  output logic busy_o,
  output logic evt_interrupt_o,
  output logic hwce_working_o
);

  import conv_wrap_pkg::*;

  seq_state_e state_q;
  seq_state_e state_d;
  logic       sink_lat_q;
  logic       src_lat_q;
  logic       busy_d1_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (trigger_i) state_d = START;
      START:   state_d = RUN;
      // job ends once both streamers reported
      RUN:     if (sink_lat_q && src_lat_q) state_d = FINISH;
      FINISH:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // done latches clear at start
  // bypassed source counts as done right away
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      sink_lat_q <= 1'b0;
      src_lat_q  <= 1'b0;
    end else if (state_q == START) begin
      sink_lat_q <= 1'b0;
      src_lat_q  <= bypass_i;
    end else begin
      if (sink_done_i) sink_lat_q <= 1'b1;
      if (src_done_i) src_lat_q <= 1'b1;
    end
  end

  assign start_sink_o    = (state_q == START);
  assign start_src_o     = (state_q == START) && !bypass_i;
  assign busy_o          = (state_q == START) || (state_q == RUN);
  // busy drops in the same cycle as the event
  assign evt_interrupt_o = (state_q == FINISH);

  // keep the clock alive one extra cycle after busy drops
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      busy_d1_q <= 1'b0;
    end else begin
      busy_d1_q <= busy_o;
    end
  end

  assign hwce_working_o = busy_o | busy_d1_q;

  // a new job is only requested while idle and never during a run
  a_no_start_in_run : assert property (@(posedge clk_gated) disable iff (!rst_n)
    trigger_i |-> (state_q == IDLE));

endmodule

`default_nettype wire

// File: src/stream_sink.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_wrap_cfg.svh"

module stream_sink (
  input  wire                          clk_gated,
  input  wire                          rst_n,
  input  wire                          start_i,
  input  conv_wrap_pkg::stream_desc_u  desc_i,
  input  wire                          sink_valid_i,
  input  wire [`CW_DATA_W-1:0]         sink_data_i,
  output logic                         sink_ready_o,
  output logic                         mem_req_o,
  input  wire                          mem_gnt_i,
  output logic [`CW_ADDR_W-1:0]        mem_addr_o,
  output logic                         mem_we_o,
  output logic [`CW_DATA_W/8-1:0]      mem_be_o,
  output logic [`CW_DATA_W-1:0]        mem_wdata_o,
  output logic                         done_o
);

  import conv_wrap_pkg::*;

  localparam int AW = `CW_ADDR_W;
  localparam int LW = `CW_LEN_W;

  stream_desc_u          desc_q;
  logic [LW-1:0]         cnt_q;
  logic                  active_q;
  logic                  pend_q;
  logic                  empty_done_q;
  logic [`CW_DATA_W-1:0] wdata_q;
  logic                  accept;
  logic                  gnt_ok;
  logic                  last;

  // one write in flight at a time
  assign sink_ready_o = active_q & ~pend_q;
  assign accept       = sink_valid_i & sink_ready_o;
  // grant only counts while the request is up
  assign gnt_ok       = mem_req_o & mem_gnt_i;
  assign last         = (cnt_q == desc_q.fld.len - 1'b1);

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      pend_q       <= 1'b0;
      cnt_q        <= '0;
      empty_done_q <= 1'b0;
    end else begin
      // zero length finishes straight away
      empty_done_q <= start_i && (desc_i.fld.len == '0);
      if (start_i) begin
        active_q <= (desc_i.fld.len != '0);
        cnt_q    <= '0;
      end else if (gnt_ok) begin
        pend_q <= 1'b0;
        cnt_q  <= cnt_q + 1'b1;
        if (last) active_q <= 1'b0;
      end else if (accept) begin
        pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_gated) begin
    if (start_i) desc_q <= desc_i;
    if (accept) wdata_q <= sink_data_i;
  end

  // word i lands at base + 4*i, counter holds until the grant
  assign mem_addr_o  = AW'(desc_q.fld.base) + (AW'(cnt_q) << 2);
  assign mem_req_o   = pend_q;
  assign mem_we_o    = 1'b1;
  assign mem_be_o    = '1;
  assign mem_wdata_o = wdata_q;
  assign done_o      = (gnt_ok & last) | empty_done_q;

  // a stalled write keeps its request, address and data
  a_req_stable : assert property (@(posedge clk_gated) disable iff (!rst_n)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_wdata_o));

endmodule

`default_nettype wire

// File: src/stream_source.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_wrap_cfg.svh"

module stream_source (
  input  wire                          clk_gated,
  input  wire                          rst_n,
  input  wire                          start_i,
  input  wire                          bypass_i,
  input  wire [`CW_DATA_W-1:0]         const_i,
  input  conv_wrap_pkg::stream_desc_u  desc_i,
  output logic                         mem_req_o,
  input  wire                          mem_gnt_i,
  output logic [`CW_ADDR_W-1:0]        mem_addr_o,
  output logic                         mem_we_o,
  input  wire [`CW_DATA_W-1:0]         mem_r_data_i,
  input  wire                          mem_r_valid_i,
  output logic                         src_valid_o,
  output logic [`CW_DATA_W-1:0]        src_data_o,
  input  wire                          src_ready_i,
  output logic                         done_o
);

  import conv_wrap_pkg::*;

  localparam int AW    = `CW_ADDR_W;
  localparam int DW    = `CW_DATA_W;
  localparam int LW    = `CW_LEN_W;
  localparam int DEPTH = `CW_FIFO_DEPTH;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  stream_desc_u  desc_q;
  logic          active_q;
  logic          empty_done_q;
  logic          rd_gnt_q;
  logic [LW-1:0] issue_cnt_q;
  logic [LW-1:0] out_cnt_q;
  logic [CW-1:0] outst_q;
  logic [CW-1:0] fifo_cnt_q;
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [DW-1:0] fifo_q [DEPTH];
  logic          room;
  logic          gnt_ok;
  logic          resp_ok;
  logic          pop;
  logic          last_out;

  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // reads in flight plus buffered words stay within the buffer
  assign room      = (int'(outst_q) + int'(fifo_cnt_q)) < DEPTH;
  assign mem_req_o = active_q && (issue_cnt_q != desc_q.fld.len) && room;
  assign mem_addr_o = AW'(desc_q.fld.base) + (AW'(issue_cnt_q) << 2);
  assign mem_we_o  = 1'b0;
  assign gnt_ok    = mem_req_o & mem_gnt_i;
  // r_valid only counts right after a granted read
  assign resp_ok   = mem_r_valid_i & rd_gnt_q;
  assign pop       = (fifo_cnt_q != '0) & src_ready_i & ~bypass_i;
  assign last_out  = (out_cnt_q == desc_q.fld.len - 1'b1);

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      empty_done_q <= 1'b0;
      rd_gnt_q     <= 1'b0;
      issue_cnt_q  <= '0;
      out_cnt_q    <= '0;
      outst_q      <= '0;
      fifo_cnt_q   <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
    end else begin
      rd_gnt_q     <= gnt_ok;
      empty_done_q <= start_i && (desc_i.fld.len == '0);
      if (start_i) begin
        active_q    <= (desc_i.fld.len != '0);
        issue_cnt_q <= '0;
        out_cnt_q   <= '0;
      end else begin
        if (gnt_ok) issue_cnt_q <= issue_cnt_q + 1'b1;
        if (pop) begin
          out_cnt_q <= out_cnt_q + 1'b1;
          if (last_out) active_q <= 1'b0;
        end
      end
      outst_q    <= outst_q + CW'(gnt_ok) - CW'(resp_ok);
      fifo_cnt_q <= fifo_cnt_q + CW'(resp_ok) - CW'(pop);
      if (resp_ok) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
    end
  end

  always_ff @(posedge clk_gated) begin
    if (start_i) desc_q <= desc_i;
    if (resp_ok) fifo_q[wr_ptr_q] <= mem_r_data_i;
  end

  // bypass drives the constant word with valid held high
  assign src_valid_o = bypass_i | (fifo_cnt_q != '0);
  assign src_data_o  = bypass_i ? const_i : fifo_q[rd_ptr_q];
  assign done_o      = (pop & last_out) | empty_done_q;

  // a response always finds a free slot
  a_no_overflow : assert property (@(posedge clk_gated) disable iff (!rst_n)
    resp_ok |-> fifo_cnt_q < CW'(DEPTH));

endmodule

`default_nettype wire

// File: testbench/tb_conv_wrap.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_wrap_cfg.svh"

module tb_conv_wrap;

  localparam int DW = `CW_DATA_W;
  localparam int AW = `CW_ADDR_W;
  // limit well above the roughly 600 cycles the tests take with stalls
  localparam int TIMEOUT_CYCLES = 5000;

  logic                      clk_gated = 1'b0;
  logic                      rst_n;
  logic                      cfg_req;
  logic                      cfg_gnt;
  logic                      cfg_we;
  logic [`CW_CFG_ADDR_W-1:0] cfg_addr;
  logic [DW-1:0]             cfg_wdata;
  logic [`CW_ID_W-1:0]       cfg_id;
  logic                      cfg_r_valid;
  logic [`CW_ID_W-1:0]       cfg_r_id;
  logic [DW-1:0]             cfg_r_rdata;
  logic                      evt_interrupt;
  logic                      hwce_working;
  logic                      sink_valid;
  logic [DW-1:0]             sink_data;
  logic                      sink_ready;
  logic                      src_valid;
  logic [DW-1:0]             src_data;
  logic                      src_ready = 1'b0;
  logic                      mem0_req;
  logic                      mem0_gnt;
  logic [AW-1:0]             mem0_addr;
  logic                      mem0_we;
  logic [DW/8-1:0]           mem0_be;
  logic [DW-1:0]             mem0_wdata;
  logic                      mem1_req;
  logic                      mem1_gnt;
  logic [AW-1:0]             mem1_addr;
  logic                      mem1_we;
  logic [DW-1:0]             mem1_r_data;
  logic                      mem1_r_valid;
  logic                      stall0 = 1'b0;
  logic                      stall1 = 1'b0;
  logic                      stall_en = 1'b0;
  logic [15:0]               lfsr_q = 16'd20;
  logic [`CW_ID_W-1:0]       next_id;
  int                        cycle_cnt = 0;

  always #4 clk_gated = ~clk_gated;

  conv_wrap_top UUT (
    .clk_gated       (clk_gated),
    .rst_n           (rst_n),
    .cfg_req_i       (cfg_req),
    .cfg_gnt_o       (cfg_gnt),
    .cfg_we_i        (cfg_we),
    .cfg_addr_i      (cfg_addr),
    .cfg_wdata_i     (cfg_wdata),
    .cfg_id_i        (cfg_id),
    .cfg_r_valid_o   (cfg_r_valid),
    .cfg_r_id_o      (cfg_r_id),
    .cfg_r_rdata_o   (cfg_r_rdata),
    .evt_interrupt_o (evt_interrupt),
    .hwce_working_o  (hwce_working),
    .sink_valid_i    (sink_valid),
    .sink_data_i     (sink_data),
    .sink_ready_o    (sink_ready),
    .src_valid_o     (src_valid),
    .src_data_o      (src_data),
    .src_ready_i     (src_ready),
    .mem0_req_o      (mem0_req),
    .mem0_gnt_i      (mem0_gnt),
    .mem0_addr_o     (mem0_addr),
    .mem0_we_o       (mem0_we),
    .mem0_be_o       (mem0_be),
    .mem0_wdata_o    (mem0_wdata),
    .mem1_req_o      (mem1_req),
    .mem1_gnt_i      (mem1_gnt),
    .mem1_addr_o     (mem1_addr),
    .mem1_we_o       (mem1_we),
    .mem1_r_data_i   (mem1_r_data),
    .mem1_r_valid_i  (mem1_r_valid)
  );

  tcdm_mem_model u_mem (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .p0_req_i     (mem0_req),
    .p0_gnt_o     (mem0_gnt),
    .p0_addr_i    (mem0_addr),
    .p0_we_i      (mem0_we),
    .p0_be_i      (mem0_be),
    .p0_wdata_i   (mem0_wdata),
    .p0_stall_i   (stall0),
    .p1_req_i     (mem1_req),
    .p1_gnt_o     (mem1_gnt),
    .p1_addr_i    (mem1_addr),
    .p1_we_i      (mem1_we),
    .p1_r_data_o  (mem1_r_data),
    .p1_r_valid_o (mem1_r_valid),
    .p1_stall_i   (stall1)
  );

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // grant stalls and ready gaps from one lfsr step per bit taken
  always @(posedge clk_gated) begin
    if (stall_en) begin
      lfsr_q = lfsr_step(lfsr_q);
      stall0 <= lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
      stall1 <= lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
      src_ready <= lfsr_q[0];
    end else begin
      stall0    <= 1'b0;
      stall1    <= 1'b0;
      src_ready <= 1'b1;
    end
  end

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  always @(posedge clk_gated) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  task automatic check_equal(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // distinct stream word per index
  function automatic logic [DW-1:0] sink_word(input int i);
    return 32'h5EED_0000 ^ (DW'(i) * 32'h0001_0103);
  endfunction

  // preload pattern over the whole byte address
  function automatic logic [DW-1:0] mem_word(input logic [AW-1:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'h0F0F_1234;
  endfunction

  // one bus access with its response checked one cycle after the request
  task automatic cfg_access(input logic we, input int addr, input logic [DW-1:0] wdata,
                            output logic [DW-1:0] rdata);
    logic [`CW_ID_W-1:0] id;
    id      = next_id;
    next_id = next_id + 16'h0011;
    @(posedge clk_gated);
    cfg_req   <= 1'b1;
    cfg_we    <= we;
    cfg_addr  <= `CW_CFG_ADDR_W'(addr);
    cfg_wdata <= wdata;
    cfg_id    <= id;
    @(negedge clk_gated);
    check_equal("cfg_gnt_o", DW'(cfg_gnt), 1);
    // nothing back yet in the request cycle
    check_equal("cfg_r_valid_o", DW'(cfg_r_valid), 0);
    @(posedge clk_gated);
    cfg_req <= 1'b0;
    cfg_we  <= 1'b0;
    @(negedge clk_gated);
    check_equal("cfg_r_valid_o", DW'(cfg_r_valid), 1);
    check_equal("cfg_r_id_o", DW'(cfg_r_id), DW'(id));
    rdata = cfg_r_rdata;
  endtask

  task automatic write_reg(input int addr, input logic [DW-1:0] data);
    logic [DW-1:0] unused_rd;
    cfg_access(1'b1, addr, data, unused_rd);
  endtask

  task automatic expect_reg(input int addr, input logic [DW-1:0] exp, input string name);
    logic [DW-1:0] rd;
    cfg_access(1'b0, addr, '0, rd);
    check_equal(name, rd, exp);
  endtask

  // sink must close ready while its write is pending
  task automatic feed_sink(input int count, input int first);
    for (int i = 0; i < count; i++) begin
      @(posedge clk_gated);
      sink_valid <= 1'b1;
      sink_data  <= sink_word(first + i);
      @(negedge clk_gated);
      if (i > 0) check_equal("sink_ready_o", DW'(sink_ready), 0);
      while (!sink_ready) @(negedge clk_gated);
    end
    @(posedge clk_gated);
    sink_valid <= 1'b0;
  endtask

  // words must come out in address order
  task automatic collect_source(input int count, input logic [AW-1:0] base);
    int k;
    k = 0;
    while (k < count) begin
      @(negedge clk_gated);
      if (src_valid && src_ready) begin
        check_equal("src_data_o", src_data, mem_word(base + AW'(4 * k)));
        k++;
      end
    end
  endtask

  // working level must hold from the trigger until the event
  task automatic wait_job_end(input logic bypass_on, input logic [DW-1:0] const_exp);
    @(negedge clk_gated);
    while (!evt_interrupt) begin
      check_equal("hwce_working_o", DW'(hwce_working), 1);
      if (bypass_on) begin
        check_equal("mem1_req_o", DW'(mem1_req), 0);
        check_equal("src_valid_o", DW'(src_valid), 1);
        check_equal("src_data_o", src_data, const_exp);
      end
      @(negedge clk_gated);
    end
    // busy already low but the working level holds one more cycle
    check_equal("hwce_working_o", DW'(hwce_working), 1);
    repeat (4) begin
      @(negedge clk_gated);
      check_equal("evt_interrupt_o", DW'(evt_interrupt), 0);
      check_equal("hwce_working_o", DW'(hwce_working), 0);
    end
    expect_reg(`CW_REG_STATUS, 0, "STATUS");
  endtask

  task automatic check_registers();
    write_reg(`CW_REG_SINK, 32'h0008_0040);
    write_reg(`CW_REG_SOURCE, 32'h0006_0100);
    write_reg(`CW_REG_CTRL, 32'h1);
    write_reg(`CW_REG_CONST, 32'hCAFE_F00D);
    expect_reg(`CW_REG_SINK, 32'h0008_0040, "SINK");
    expect_reg(`CW_REG_SOURCE, 32'h0006_0100, "SOURCE");
    expect_reg(`CW_REG_CTRL, 32'h1, "CTRL");
    expect_reg(`CW_REG_CONST, 32'hCAFE_F00D, "CONST");
    write_reg(`CW_REG_CTRL, 32'h0);
    expect_reg(`CW_REG_CTRL, 32'h0, "CTRL");
    expect_reg(`CW_REG_STATUS, 32'h0, "STATUS");
  endtask

  task automatic run_sink_job();
    // 8 words at 0x40 with an empty source
    write_reg(`CW_REG_SINK, {16'd8, 16'h0040});
    write_reg(`CW_REG_SOURCE, {16'd0, 16'h0100});
    stall_en = 1'b1;
    write_reg(`CW_REG_TRIGGER, 32'h1);
    // job in START reports busy
    expect_reg(`CW_REG_STATUS, 32'h1, "STATUS");
    fork
      feed_sink(8, 0);
      wait_job_end(1'b0, '0);
    join
    stall_en = 1'b0;
    for (int i = 0; i < 8; i++) begin
      check_equal("mem0 word", u_mem.read_word(AW'(32'h40 + 4 * i)), sink_word(i));
    end
  endtask

  task automatic run_source_job();
    for (int i = 0; i < 6; i++) begin
      u_mem.load_word(AW'(32'h100 + 4 * i), mem_word(AW'(32'h100 + 4 * i)));
    end
    write_reg(`CW_REG_SINK, {16'd0, 16'h0040});
    write_reg(`CW_REG_SOURCE, {16'd6, 16'h0100});
    stall_en = 1'b1;
    write_reg(`CW_REG_TRIGGER, 32'h1);
    fork
      collect_source(6, 32'h100);
      wait_job_end(1'b0, '0);
    join
    stall_en = 1'b0;
    // no extra word left behind
    check_equal("src_valid_o", DW'(src_valid), 0);
  endtask

  task automatic run_bypass_job();
    // source length set but must stay unused
    write_reg(`CW_REG_SINK, {16'd4, 16'h0080});
    write_reg(`CW_REG_SOURCE, {16'd6, 16'h0100});
    write_reg(`CW_REG_CTRL, 32'h1);
    write_reg(`CW_REG_CONST, 32'h1234_5678);
    stall_en = 1'b1;
    write_reg(`CW_REG_TRIGGER, 32'h1);
    fork
      feed_sink(4, 16);
      wait_job_end(1'b1, 32'h1234_5678);
    join
    stall_en = 1'b0;
    for (int i = 0; i < 4; i++) begin
      check_equal("mem0 word", u_mem.read_word(AW'(32'h80 + 4 * i)), sink_word(16 + i));
    end
    write_reg(`CW_REG_CTRL, 32'h0);
  endtask

  initial begin
    rst_n      = 1'b0;
    cfg_req    = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    cfg_id     = '0;
    sink_valid = 1'b0;
    sink_data  = '0;
    next_id    = 16'h0100;
    repeat (3) @(posedge clk_gated);
    rst_n <= 1'b1;
    @(negedge clk_gated);
    // idle outputs out of reset
    check_equal("cfg_r_valid_o", DW'(cfg_r_valid), 0);
    check_equal("evt_interrupt_o", DW'(evt_interrupt), 0);
    check_equal("hwce_working_o", DW'(hwce_working), 0);
    check_equal("mem0_req_o", DW'(mem0_req), 0);
    check_equal("mem1_req_o", DW'(mem1_req), 0);
    check_equal("sink_ready_o", DW'(sink_ready), 0);
    check_equal("src_valid_o", DW'(src_valid), 0);
    check_registers();
    run_sink_job();
    run_source_job();
    run_bypass_job();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tcdm_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_wrap_cfg.svh"

module tcdm_mem_model #(
  parameter int WORDS = 256
) (
  input  wire                      clk_gated,
  input  wire                      rst_n,
  // port 0 takes writes only
  input  wire                      p0_req_i,
  output logic                     p0_gnt_o,
  input  wire [`CW_ADDR_W-1:0]     p0_addr_i,
  input  wire                      p0_we_i,
  input  wire [`CW_DATA_W/8-1:0]   p0_be_i,
  input  wire [`CW_DATA_W-1:0]     p0_wdata_i,
  input  wire                      p0_stall_i,
  // port 1 serves reads only
  input  wire                      p1_req_i,
  output logic                     p1_gnt_o,
  input  wire [`CW_ADDR_W-1:0]     p1_addr_i,
  input  wire                      p1_we_i,
  output logic [`CW_DATA_W-1:0]    p1_r_data_o,
  output logic                     p1_r_valid_o,
  input  wire                      p1_stall_i
);

  localparam int IW = $clog2(WORDS);

  logic [`CW_DATA_W-1:0] mem [WORDS];
  logic                  rd_fire;

  // stall input from the random source holds the grant back
  assign p0_gnt_o = p0_req_i & ~p0_stall_i;
  assign p1_gnt_o = p1_req_i & ~p1_stall_i;
  assign rd_fire  = p1_gnt_o & ~p1_we_i;

  // byte-enabled write on the grant edge
  always @(posedge clk_gated) begin
    if (p0_gnt_o && p0_we_i) begin
      for (int b = 0; b < `CW_DATA_W/8; b++) begin
        if (p0_be_i[b]) mem[p0_addr_i[IW+1:2]][8*b +: 8] <= p0_wdata_i[8*b +: 8];
      end
    end
  end

  // read answer exactly one cycle after the grant
  always @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      p1_r_valid_o <= 1'b0;
    end else begin
      p1_r_valid_o <= rd_fire;
    end
  end

  always @(posedge clk_gated) begin
    if (rd_fire) p1_r_data_o <= mem[p1_addr_i[IW+1:2]];
  end

  // backdoor access for setup and result checks
  task automatic load_word(input logic [`CW_ADDR_W-1:0] addr,
                           input logic [`CW_DATA_W-1:0] data);
    mem[addr[IW+1:2]] <= data;
  endtask

  function automatic logic [`CW_DATA_W-1:0] read_word(input logic [`CW_ADDR_W-1:0] addr);
    return mem[addr[IW+1:2]];
  endfunction

endmodule

`default_nettype wire
